//--- flist.f
common/cache_pkg.sv
common/cache_if.sv
common/mem_if.sv
cache/cache_store.sv
cache/cache_ctrl.sv
design/main_mem.sv
design/cache_top.sv
test/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the cache testbench with Verilator and run it
# exit status is the simulator's, nonzero on any failure
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module cache_tb -f flist.f -o cache_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/cache_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation failed with status $sim_status"
	exit $sim_status
fi

echo "simulation finished cleanly"
exit 0

//--- test/cache_tb.sv
// testbench for the two-way write-back cache with its backing memory
// a word-level reference model predicts rdata and hit, concurrent assertions compare on done
`timescale 1ns/1ps

module cache_tb;

	logic        clk;
	logic        rst_n;
	logic        req_rd;
	logic        req_wr;
	logic [15:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        hit;
	logic        done;
	logic        busy;

	// reference model, memory words plus per-set tags, valids and lru
	bit [31:0] model_mem [65536];   // starts at zero like the memory
	bit [7:0]  m_tag     [2][64];
	bit        m_valid   [2][64];
	bit        m_lru     [64];      // 1 means way1 is next victim

	logic        exp_hit   = 1'b0;
	logic [31:0] exp_rdata = '0;
	logic        exp_rd    = 1'b0;  // rdata only checked on reads
	int          n_issued  = 0;
	int          cycles    = 0;

	cache_top #(
		.MEM_LATENCY (4)
	) cache_top_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.req_rd (req_rd),
		.req_wr (req_wr),
		.addr   (addr),
		.wdata  (wdata),
		.rdata  (rdata),
		.hit    (hit),
		.done   (done),
		.busy   (busy)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;   // 4 ns period

	task automatic report_mismatch(input string sig, input logic [31:0] expv,
	                               input logic [31:0] actv);
		$display("[ERROR] time %0t: %s expected %h, got %h", $time, sig, expv, actv);
		$display(">>> FAIL");
		$fatal(1, "wrong value on %s", sig);
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	// predict hit and read data, then update the model as the cache will
	task automatic model_access(input logic is_wr, input logic [15:0] a, input logic [31:0] d);
		logic [7:0] t;
		logic [5:0] s;
		logic       w;
		logic       found;
		t     = a[15:8];   // tag on top
		s     = a[7:2];    // set index
		found = 1'b1;
		if (m_valid[0][s] && m_tag[0][s] == t)
			w = 1'b0;
		else if (m_valid[1][s] && m_tag[1][s] == t)
			w = 1'b1;
		else begin
			found = 1'b0;
			w     = m_lru[s];       // victim regardless of valid
			m_tag[w][s]   = t;
			m_valid[w][s] = 1'b1;
		end
		m_lru[s]  = (w == 1'b0);    // point away from the used way
		exp_hit   = found;
		exp_rd    = !is_wr;
		exp_rdata = model_mem[a];
		if (is_wr)
			model_mem[a] = d;
	endtask

	// one request, called and returning 1 ns after a rising edge
	task automatic issue(input logic is_wr, input logic [15:0] a, input logic [31:0] d);
		model_access(is_wr, a, d);
		addr     = a;
		wdata    = d;
		req_rd   = !is_wr;
		req_wr   = is_wr;
		n_issued = n_issued + 1;
		@(posedge clk);
		#1;
		req_rd = 1'b0;
		req_wr = 1'b0;
		while (!done) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);   // let the checks see done before expectations move
		#1;
	endtask

	a_hit_value: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> hit == exp_hit)
		else report_mismatch("hit", 32'(exp_hit), 32'($sampled(hit)));

	a_rdata_value: assert property (@(posedge clk) disable iff (!rst_n)
		done && exp_rd |-> rdata == exp_rdata)
		else report_mismatch("rdata", exp_rdata, $sampled(rdata));

	// quiet until the first request
	a_idle_start: assert property (@(posedge clk) disable iff (!rst_n)
		n_issued == 0 |-> !busy && !done)
		else stop_run("busy or done went high before any request");

	a_hit_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(req_rd || req_wr) && exp_hit |=> busy && !done)
		else stop_run("busy not high in the cycle after a hit request");

	a_hit_done: assert property (@(posedge clk) disable iff (!rst_n)
		(req_rd || req_wr) && exp_hit |-> ##2 (done && !busy))
		else stop_run("done did not arrive two cycles after a hit request");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else stop_run("done lasted longer than one cycle");

	// hang guard, limit grows with each request
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > 40 * n_issued + 100)
			stop_run("timeout waiting for done");
	end

	initial begin : main_seq
		logic [15:0] a;
		logic [31:0] d;
		logic        is_wr;
		void'($urandom(2));
		rst_n  = 1'b0;
		req_rd = 1'b0;
		req_wr = 1'b0;
		addr   = '0;
		wdata  = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (3) @(posedge clk);   // idle stretch before the first request
		#1;

		// cold reads return zero and miss
		issue(1'b0, 16'h1234, '0);
		issue(1'b0, 16'hbeef, '0);
		issue(1'b0, 16'h1235, '0);   // same line, now a hit

		// write then read back, second pair stays in the same line
		issue(1'b1, 16'h0104, 32'hcafe_0001);
		issue(1'b0, 16'h0104, '0);
		issue(1'b1, 16'h0107, 32'h1357_9bdf);
		issue(1'b0, 16'h0107, '0);
		repeat (3) issue(1'b0, 16'h0105, '0);   // back to back hits

		// three tags on set 0x15, the third write evicts a dirty line
		issue(1'b1, {8'h21, 6'h15, 2'd2}, 32'haaaa_0021);
		issue(1'b1, {8'h42, 6'h15, 2'd2}, 32'hbbbb_0042);
		issue(1'b1, {8'h63, 6'h15, 2'd2}, 32'hcccc_0063);
		issue(1'b0, {8'h21, 6'h15, 2'd2}, '0);   // oldest first
		issue(1'b0, {8'h42, 6'h15, 2'd2}, '0);
		issue(1'b0, {8'h63, 6'h15, 2'd2}, '0);
		issue(1'b0, {8'h63, 6'h15, 2'd2}, '0);   // now resident

		// random mix, 4 tags x 4 sets x 4 words
		for (int n = 0; n < 300; n++) begin
			a     = {8'h70 + 8'($urandom_range(0, 3)), 6'h20 + 6'($urandom_range(0, 3)),
			         2'($urandom_range(0, 3))};
			is_wr = 1'($urandom_range(0, 1));
			d     = $urandom;
			issue(is_wr, a, d);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- design/cache_top.sv
// cache with backing memory, plain CPU strobes in and done pulse out
// MEM_LATENCY passes through to the memory model
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
	parameter int MEM_LATENCY = 4
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  req_rd,
	input  logic  req_wr,
	input  addr_t addr,
	input  word_t wdata,
	output word_t rdata,
	output logic  hit,
	output logic  done,
	output logic  busy
);

	cache_if cbus ();   // ctrl to store
	mem_if   mbus ();   // ctrl to memory

	cache_ctrl ctrl_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.req_rd (req_rd),
		.req_wr (req_wr),
		.addr   (addr),
		.wdata  (wdata),
		.rdata  (rdata),
		.hit    (hit),
		.done   (done),
		.busy   (busy),
		.bus    (cbus.ctrl),
		.mem    (mbus.ctrl)
	);

	cache_store store_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (cbus.store)
	);

	main_mem #(
		.MEM_LATENCY (MEM_LATENCY)
	) mem_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (mbus.mem)
	);

endmodule

//--- design/main_mem.sv
// line-wide backing memory behind the cache
// each access completes MEM_LATENCY cycles after its strobe with a ready pulse
`timescale 1ns/1ps

module main_mem import cache_pkg::*; #(
	parameter int MEM_LATENCY = 4
) (
	input logic clk,
	input logic rst_n,
	mem_if.mem  bus
);

	localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

	line_t mem_arr [MEM_LINES];

	line_addr_t       addr_q;    // latched at the strobe
	line_t            wdata_q;
	logic             wr_q;      // pending op is a write
	logic             active;
	logic [CNT_W-1:0] cnt;       // wait cycles left
	logic             due;

	assign due = active && (cnt == '0);

	// contents start at zero, reset leaves them alone
	initial begin : zero_fill
		for (int i = 0; i < MEM_LINES; i++)
			mem_arr[i] = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active    <= 1'b0;
			cnt       <= '0;
			wr_q      <= 1'b0;
			bus.ready <= 1'b0;
		end else begin
			bus.ready <= 1'b0;       // single cycle pulse
			if (bus.rd || bus.wr) begin
				active <= 1'b1;
				cnt    <= CNT_W'(MEM_LATENCY - 1);
				wr_q   <= bus.wr;
			end else if (due) begin
				active    <= 1'b0;
				bus.ready <= 1'b1;
			end else if (active) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// array access lands with ready
	always_ff @(posedge clk) begin
		if (bus.rd || bus.wr) begin
			addr_q  <= bus.addr;
			wdata_q <= bus.wdata;
		end
		if (due) begin
			if (wr_q)
				mem_arr[addr_q] <= wdata_q;
			else
				bus.rdata <= mem_arr[addr_q];
		end
	end

	a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(bus.rd && bus.wr));

endmodule

//--- cache/cache_ctrl.sv
// request FSM for the two-way cache
// serves hits, writes back dirty victims, refills and then rechecks as a hit
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  req_rd,
	input  logic  req_wr,
	input  addr_t addr,
	input  word_t wdata,
	output word_t rdata,
	output logic  hit,
	output logic  done,
	output logic  busy,
	cache_if.ctrl bus,
	mem_if.ctrl   mem
);

	ctrl_state_t state, nxt_state;

	// request held for the whole access
	addr_t req_addr;
	word_t req_wdata;
	logic  req_is_wr;

	logic  missed;      // this access went to memory at least once
	logic  victim_q;    // way chosen for the refill
	logic  mem_pend;    // memory transfer outstanding

	logic     accept;
	tag_t     req_tag;
	index_t   req_idx;
	off_t     req_off;
	logic     any_hit;
	logic     victim_dirty;
	way_sel_t hit_sel;
	way_sel_t victim_sel;
	line_t    merged;

	// new request taken in IDLE or in the DONE cycle, busy is low in both
	assign accept  = (state == IDLE || state == DONE) && (req_rd || req_wr);
	assign req_tag = addr_tag(req_addr);
	assign req_idx = addr_index(req_addr);
	assign req_off = addr_off(req_addr);

	assign any_hit      = bus.hit0 || bus.hit1;
	assign hit_sel      = bus.way ? WAY_SEL_W1 : WAY_SEL_W0;
	assign victim_sel   = victim_q ? WAY_SEL_W1 : WAY_SEL_W0;
	assign victim_dirty = bus.way ? (bus.valid1 && bus.dirty1)
	                              : (bus.valid0 && bus.dirty0);

	assign busy = (state != IDLE) && (state != DONE);
	assign done = (state == DONE);

	// write data dropped into the stored line
	always_comb begin : merge_word
		merged          = bus.data_out;
		merged[req_off] = req_wdata;
	end

	always_comb begin : fsm_comb
		nxt_state    = state;
		bus.index    = accept ? addr_index(addr) : req_idx;   // read the new set at once
		bus.rd       = accept || (state == FILL);
		bus.wr       = 1'b0;
		bus.way_sel  = WAY_SEL_NONE;
		bus.tag_in   = req_tag;
		bus.dirty_in = 1'b0;
		bus.data_in  = merged;
		bus.touch    = 1'b0;
		mem.rd       = 1'b0;
		mem.wr       = 1'b0;
		mem.addr     = {req_tag, req_idx};
		mem.wdata    = bus.data_out;    // victim line, stable until the next rd

		unique case (state)
			IDLE, DONE: begin
				if (accept)
					nxt_state = CHECK;
				else
					nxt_state = IDLE;
			end

			CHECK: begin
				if (any_hit) begin
					bus.touch   = 1'b1;
					bus.way_sel = hit_sel;
					if (req_is_wr) begin
						bus.wr       = 1'b1;   // merged line goes back dirty
						bus.dirty_in = 1'b1;
					end
					nxt_state = DONE;
				end else if (victim_dirty) begin
					nxt_state = WB_REQ;
				end else begin
					nxt_state = RF_REQ;   // clean or empty victim, just refill
				end
			end

			WB_REQ: begin
				mem.wr    = 1'b1;
				mem.addr  = {bus.tag_out, req_idx};   // victim's own line address
				nxt_state = WB_WAIT;
			end

			WB_WAIT: begin
				if (mem.ready)
					nxt_state = RF_REQ;
			end

			RF_REQ: begin
				mem.rd    = 1'b1;
				nxt_state = RF_WAIT;
			end

			RF_WAIT: begin
				if (mem.ready) begin
					bus.wr      = 1'b1;       // fill clean straight off rdata
					bus.way_sel = victim_sel;
					bus.data_in = mem.rdata;
					nxt_state   = FILL;
				end
			end

			FILL: begin
				nxt_state = CHECK;   // rd issued above, recheck as a hit
			end

			default: begin
				nxt_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			req_is_wr <= 1'b0;
			missed    <= 1'b0;
			victim_q  <= 1'b0;
			hit       <= 1'b0;
			mem_pend  <= 1'b0;
		end else begin
			state <= nxt_state;
			if (accept) begin
				req_is_wr <= req_wr;
				missed    <= 1'b0;
			end
			if (state == CHECK && !any_hit) begin
				missed   <= 1'b1;
				victim_q <= bus.way;    // lru victim when nothing hit
			end
			if (state == CHECK && any_hit)
				hit <= !missed;         // a refilled access reports 0
			if (mem.rd || mem.wr)
				mem_pend <= 1'b1;
			else if (mem.ready)
				mem_pend <= 1'b0;
		end
	end

	// request payload and read data
	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr  <= addr;
			req_wdata <= wdata;
		end
		if (state == CHECK && any_hit && !req_is_wr)
			rdata <= bus.data_out[req_off];
	end

	a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !(req_rd || req_wr));

	a_rd_xor_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(req_rd && req_wr));

	// memory handles a single transfer until it answers ready
	a_one_mem_xfer: assert property (@(posedge clk) disable iff (!rst_n)
		mem_pend |-> !(mem.rd || mem.wr));

endmodule

//--- cache/cache_store.sv
// two-way set-associative line and flag storage with one lru bit per set
// reads are registered, so hit and line data appear the cycle after rd
`timescale 1ns/1ps

module cache_store import cache_pkg::*; (
	input logic    clk,
	input logic    rst_n,
	cache_if.store bus
);

	// per-way arrays, way index first
	line_t line_mem  [2][NUM_SETS];
	tag_t  tag_mem   [2][NUM_SETS];
	logic  dirty_mem [2][NUM_SETS];

	logic [1:0][NUM_SETS-1:0] valid_r;   // cleared on reset
	logic [NUM_SETS-1:0]      lru_r;     // 1 means way1 is the victim

	line_t [1:0] line_q;                 // registered read lines
	flag_t [1:0] flag_q;                 // registered read flags
	logic        lru_q;

	logic [1:0]  we;                     // per-way write enable

	assign we[0] = bus.wr && (bus.way_sel == WAY_SEL_W0 || bus.way_sel == WAY_SEL_ALL);
	assign we[1] = bus.wr && (bus.way_sel == WAY_SEL_W1 || bus.way_sel == WAY_SEL_ALL);

	// data, tag and dirty arrays plus the line read register
	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (we[w]) begin
				line_mem[w][bus.index]  <= bus.data_in;
				tag_mem[w][bus.index]   <= bus.tag_in;
				dirty_mem[w][bus.index] <= bus.dirty_in;
			end
			if (bus.rd)
				line_q[w] <= line_mem[w][bus.index];
		end
	end

	// valid, lru and the flag read register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_r <= '0;
			lru_r   <= '0;
			flag_q  <= '0;
			lru_q   <= 1'b0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (we[w])
					valid_r[w][bus.index] <= 1'b1;   // a filled line is always valid
				if (bus.rd) begin
					flag_q[w].tag   <= tag_mem[w][bus.index];
					flag_q[w].valid <= valid_r[w][bus.index];
					flag_q[w].dirty <= dirty_mem[w][bus.index];
				end
			end
			if (bus.touch)
				lru_r[bus.index] <= (bus.way_sel == WAY_SEL_W0);  // point away from it
			if (bus.rd)
				lru_q <= lru_r[bus.index];
		end
	end

	// tag compare against the request held by the controller
	assign bus.hit0   = flag_q[0].valid && (flag_q[0].tag == bus.tag_in);
	assign bus.hit1   = flag_q[1].valid && (flag_q[1].tag == bus.tag_in);
	assign bus.valid0 = flag_q[0].valid;
	assign bus.valid1 = flag_q[1].valid;
	assign bus.dirty0 = flag_q[0].dirty;
	assign bus.dirty1 = flag_q[1].dirty;

	// hit way wins, otherwise hand out the lru victim
	assign bus.way      = bus.hit1 ? 1'b1 : (bus.hit0 ? 1'b0 : lru_q);
	assign bus.tag_out  = flag_q[bus.way].tag;
	assign bus.data_out = line_q[bus.way];

	// one port, so a read and a write never share a cycle
	a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(bus.rd && bus.wr));

	// a tag lives in at most one way of a set
	a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
		!(bus.hit0 && bus.hit1));

endmodule

//--- common/mem_if.sv
// line-wide bus between cache controller and main memory
// one strobe per transfer, ready pulses once when it completes
`timescale 1ns/1ps

interface mem_if import cache_pkg::*; ();

	logic       rd;      // fetch line
	logic       wr;      // write back line
	line_addr_t addr;
	line_t      wdata;
	line_t      rdata;   // valid with ready on a read
	logic       ready;

	modport ctrl (
		output rd, wr, addr, wdata,
		input  rdata, ready
	);

	modport mem (
		input  rd, wr, addr, wdata,
		output rdata, ready
	);

endinterface

//--- common/cache_if.sv
// controller to store bus, ctrl side drives the set access and the store answers
// with flags and the selected line one cycle after rd
`timescale 1ns/1ps

interface cache_if import cache_pkg::*; ();

	index_t   index;      // set being accessed
	logic     rd;         // one cycle read strobe
	logic     wr;         // write into way_sel
	way_sel_t way_sel;
	tag_t     tag_in;     // compared and written
	logic     dirty_in;
	line_t    data_in;
	logic     touch;      // lru update for way_sel

	logic     hit0;
	logic     hit1;
	logic     valid0;
	logic     valid1;
	logic     dirty0;
	logic     dirty1;
	logic     way;        // hit way, else the lru victim
	tag_t     tag_out;
	line_t    data_out;

	modport ctrl (
		output index, rd, wr, way_sel, tag_in, dirty_in, data_in, touch,
		input  hit0, hit1, valid0, valid1, dirty0, dirty1, way, tag_out, data_out
	);

	modport store (
		input  index, rd, wr, way_sel, tag_in, dirty_in, data_in, touch,
		output hit0, hit1, valid0, valid1, dirty0, dirty1, way, tag_out, data_out
	);

endinterface

//--- common/cache_pkg.sv
// shared cache geometry, address fields and enums
// imported by the controller, the store, the memory model and both bus interfaces
package cache_pkg;

	localparam int ADDR_W     = 16;                       // word address
	localparam int IDX_W      = 6;                        // 64 sets
	localparam int OFF_W      = 2;                        // 4 words per line
	localparam int TAG_W      = ADDR_W - IDX_W - OFF_W;   // 8 tag bits
	localparam int NUM_SETS   = 1 << IDX_W;
	localparam int LINE_WORDS = 1 << OFF_W;
	localparam int MEM_LINES  = 1 << (TAG_W + IDX_W);     // backing store depth

	typedef logic [ADDR_W-1:0]        addr_t;
	typedef logic [IDX_W-1:0]         index_t;
	typedef logic [TAG_W-1:0]         tag_t;
	typedef logic [OFF_W-1:0]         off_t;
	typedef logic [31:0]              word_t;
	typedef word_t [LINE_WORDS-1:0]   line_t;        // 128b, word 0 in the low bits
	typedef logic [TAG_W+IDX_W-1:0]   line_addr_t;   // {tag, index}

	// which way a store write or touch applies to
	typedef enum logic [1:0] {
		WAY_SEL_NONE,
		WAY_SEL_W0,
		WAY_SEL_W1,
		WAY_SEL_ALL
	} way_sel_t;

	typedef struct packed {
		tag_t tag;
		logic valid;
		logic dirty;
	} flag_t;

	typedef enum logic [2:0] {
		IDLE, CHECK, WB_REQ, WB_WAIT, RF_REQ, RF_WAIT, FILL, DONE
	} ctrl_state_t;

	// address field split, tag on top
	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFF_W +: IDX_W];
	endfunction

	function automatic off_t addr_off(addr_t a);
		return a[OFF_W-1:0];
	endfunction

endpackage
